//--- soc_mmio_pkg.sv
package soc_mmio_pkg;

    // ========================================================================
    // Bus widths
    // ========================================================================
    localparam int data_w = 32;                 // Read and write data
    localparam int addr_w = 32;                 // Byte address
    localparam int strb_w = 4;                  // One strobe per byte lane

    typedef logic [7:0] byte_t;                 // UART payload

    // Master side, held stable until ready
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wstrb;
    } mmio_req_t;

    // Peripheral side, ready is a one-cycle pulse
    typedef struct packed {
        logic              ready;
        logic [data_w-1:0] rdata;
    } mmio_rsp_t;

    // Interrupt lines toward the CPU
    typedef struct packed {
        logic timer_irq;                        // IRQ[0]
        logic soft_irq;                         // IRQ[1]
    } irq_lines_t;

    // ========================================================================
    // Address map
    // ========================================================================
    // Region tags, compared against addr[31:4]
    localparam logic [addr_w-5:0] uart_base  = 28'h8000000;   // 0x8000000x
    localparam logic [addr_w-5:0] timer_base = 28'h8000002;   // 0x8000002x

    // Board I/O, exact word matches
    localparam logic [addr_w-1:0] addr_led      = 32'h80000010;
    localparam logic [addr_w-1:0] addr_button   = 32'h80000018;
    localparam logic [addr_w-1:0] addr_soft_irq = 32'h80000040;

    // UART word offsets
    localparam logic [3:0] uart_off_tx     = 4'h0;
    localparam logic [3:0] uart_off_rx     = 4'h4;
    localparam logic [3:0] uart_off_status = 4'h8;

    // Timer word offsets
    localparam logic [3:0] timer_off_period = 4'h0;
    localparam logic [3:0] timer_off_ctrl   = 4'h4;
    localparam logic [3:0] timer_off_status = 4'h8;
    localparam logic [3:0] timer_off_count  = 4'hC;

    localparam int timer_w = 32;                // Counter and period width

endpackage

//--- mmio_bus_ctrl.sv
`timescale 1ns/1ps

module mmio_bus_ctrl (
    input  logic                    clk,
    input  logic                    global_resetn,
    input  soc_mmio_pkg::mmio_req_t req,          // From CPU data port
    output soc_mmio_pkg::mmio_rsp_t rsp,          // Back to CPU
    output soc_mmio_pkg::mmio_req_t io_req,
    output soc_mmio_pkg::mmio_req_t uart_req,
    output soc_mmio_pkg::mmio_req_t timer_req,
    input  soc_mmio_pkg::mmio_rsp_t io_rsp,
    input  soc_mmio_pkg::mmio_rsp_t uart_rsp,
    input  soc_mmio_pkg::mmio_rsp_t timer_rsp
);

    localparam int aw = soc_mmio_pkg::addr_w;

    logic hit_io;       // LED, button or soft IRQ word
    logic hit_uart;     // 0x8000000x
    logic hit_timer;    // 0x8000002x
    logic hit_none;     // Nothing claims it
    logic def_ready;    // Default responder strobe

    // ========================================================================
    // Region decode
    // ========================================================================
    always_comb begin
        hit_io    = (req.addr == soc_mmio_pkg::addr_led) ||
                    (req.addr == soc_mmio_pkg::addr_button) ||
                    (req.addr == soc_mmio_pkg::addr_soft_irq);
        hit_uart  = (req.addr[aw-1:4] == soc_mmio_pkg::uart_base);
        hit_timer = (req.addr[aw-1:4] == soc_mmio_pkg::timer_base);
        hit_none  = !(hit_io || hit_uart || hit_timer);
    end

    // Same fields to everyone, valid only to the owner
    always_comb begin
        io_req          = req;
        io_req.valid    = req.valid && hit_io;
        uart_req        = req;
        uart_req.valid  = req.valid && hit_uart;
        timer_req       = req;
        timer_req.valid = req.valid && hit_timer;
    end

    // ========================================================================
    // Default responder
    // ========================================================================
    // Unmapped access still completes in one cycle
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            def_ready <= 1'b0;
        end else begin
            def_ready <= req.valid && hit_none && !def_ready;   // Guard on own ready
        end
    end

    // Response mux, address held stable through ready
    always_comb begin
        if (hit_io) begin
            rsp = io_rsp;
        end else if (hit_uart) begin
            rsp = uart_rsp;
        end else if (hit_timer) begin
            rsp = timer_rsp;
        end else begin
            rsp.ready = def_ready;
            rsp.rdata = '0;                 // Stray reads see zero
        end
    end

    // Only one responder may answer in any cycle
    a_one_ready : assert property (@(posedge clk) disable iff (!global_resetn)
        $onehot0({io_rsp.ready, uart_rsp.ready, timer_rsp.ready, def_ready}))
        else $error("mmio_bus_ctrl: more than one peripheral ready");

endmodule

//--- board_io.sv
`timescale 1ns/1ps

module board_io #(
    parameter int sync_stages = 2           // Button synchroniser depth
) (
    input  logic                    clk,
    input  logic                    global_resetn,
    input  soc_mmio_pkg::mmio_req_t req,
    output soc_mmio_pkg::mmio_rsp_t rsp,
    input  logic [1:0]              buttons_n,  // Active low pins
    output logic [1:0]              leds,
    output logic                    soft_irq    // One-cycle pulse
);

    localparam int dw = soc_mmio_pkg::data_w;

    logic [sync_stages-1:0][1:0] sync_q;    // Stage 0 samples the pins
    logic [1:0]                  btn;       // Pressed = 1
    logic                        accept;

    assign btn    = sync_q[sync_stages-1];
    assign accept = req.valid && !rsp.ready;

    // ========================================================================
    // Button synchroniser
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= ~buttons_n;        // Invert to active high
            for (int i = 1; i < sync_stages; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // ========================================================================
    // Register access
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            rsp.ready <= 1'b0;
            leds      <= 2'b00;
            soft_irq  <= 1'b0;
        end else begin
            rsp.ready <= accept;
            soft_irq  <= 1'b0;              // Default low

            if (accept && req.write) begin
                if (req.addr == soc_mmio_pkg::addr_led && req.wstrb[0]) begin
                    leds <= req.wdata[1:0];
                end
                if (req.addr == soc_mmio_pkg::addr_soft_irq) begin
                    soft_irq <= 1'b1;       // Lines up with ready
                end
            end
        end
    end

    // Read data, no reset needed on payload
    always_ff @(posedge clk) begin
        if (accept && !req.write) begin
            case (req.addr)
                soc_mmio_pkg::addr_led:    rsp.rdata <= {{(dw-2){1'b0}}, leds};
                soc_mmio_pkg::addr_button: rsp.rdata <= {{(dw-2){1'b0}}, btn};
                default:                   rsp.rdata <= '0;   // Soft IRQ is write-only
            endcase
        end
    end

endmodule

//--- uart_rx_fifo.sv
`timescale 1ns/1ps

module uart_rx_fifo #(
    parameter int rx_addr_bits = 4          // Depth is 2**rx_addr_bits
) (
    input  logic                clk,
    input  logic                global_resetn,
    input  logic                wr_en,
    input  soc_mmio_pkg::byte_t wr_data,
    input  logic                rd_en,      // Pop the head entry
    output soc_mmio_pkg::byte_t rd_data,    // Head, shown without popping
    output logic                full,
    output logic                empty
);

    localparam int depth = 1 << rx_addr_bits;

    soc_mmio_pkg::byte_t mem [depth];
    logic [rx_addr_bits:0] wr_ptr;          // MSB is the wrap bit
    logic [rx_addr_bits:0] rd_ptr;

    // ========================================================================
    // Flags
    // ========================================================================
    // Same index, wrap bits differ -> full
    assign full  = (wr_ptr[rx_addr_bits] != rd_ptr[rx_addr_bits]) &&
                   (wr_ptr[rx_addr_bits-1:0] == rd_ptr[rx_addr_bits-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign rd_data = mem[rd_ptr[rx_addr_bits-1:0]];     // Oldest entry

    // ========================================================================
    // Pointers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[rx_addr_bits-1:0]] <= wr_data;
        end
    end

    // Caller drops bytes when full and never pops an empty buffer
    a_no_overflow : assert property (@(posedge clk) disable iff (!global_resetn)
        wr_en |-> !full)
        else $error("uart_rx_fifo: write while full");

    a_no_underflow : assert property (@(posedge clk) disable iff (!global_resetn)
        rd_en |-> !empty)
        else $error("uart_rx_fifo: read while empty");

endmodule

//--- uart_regs.sv
`timescale 1ns/1ps

module uart_regs #(
    parameter int rx_addr_bits = 4          // Receive buffer size, log2
) (
    input  logic                    clk,
    input  logic                    global_resetn,
    input  soc_mmio_pkg::mmio_req_t req,
    output soc_mmio_pkg::mmio_rsp_t rsp,
    input  soc_mmio_pkg::byte_t     rx_byte,
    input  logic                    rx_valid,   // One-cycle strobe
    output soc_mmio_pkg::byte_t     tx_byte,
    output logic                    tx_valid,   // One-cycle pulse
    input  logic                    tx_busy     // Level from transmitter
);

    localparam int dw = soc_mmio_pkg::data_w;

    soc_mmio_pkg::byte_t rx_head;
    logic                rx_full;
    logic                rx_empty;
    logic                accept;
    logic                pop;
    logic [3:0]          off;

    assign accept = req.valid && !rsp.ready;
    assign off    = req.addr[3:0];
    // Pop only on a real read of a non-empty buffer
    assign pop    = accept && !req.write && (off == soc_mmio_pkg::uart_off_rx) && !rx_empty;

    uart_rx_fifo #(
        .rx_addr_bits (rx_addr_bits)
    ) rx_fifo_inst (
        .clk           (clk),
        .global_resetn (global_resetn),
        .wr_en         (rx_valid && !rx_full),  // Overrun bytes are dropped
        .wr_data       (rx_byte),
        .rd_en         (pop),
        .rd_data       (rx_head),
        .full          (rx_full),
        .empty         (rx_empty)
    );

    // ========================================================================
    // Handshake and transmit strobe
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            rsp.ready <= 1'b0;
            tx_valid  <= 1'b0;
        end else begin
            rsp.ready <= accept;
            tx_valid  <= accept && req.write && (off == soc_mmio_pkg::uart_off_tx) && !tx_busy;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (accept && req.write && off == soc_mmio_pkg::uart_off_tx) begin
            tx_byte <= req.wdata[7:0];
        end
        if (accept && !req.write) begin
            case (off)
                soc_mmio_pkg::uart_off_rx:     rsp.rdata <= pop ? {{(dw-8){1'b0}}, rx_head} : '0;
                soc_mmio_pkg::uart_off_status: rsp.rdata <= {{(dw-3){1'b0}},
                                                             rx_full, rx_empty, tx_busy};
                default:                       rsp.rdata <= '0;
            endcase
        end
    end

endmodule

//--- tick_timer.sv
`timescale 1ns/1ps

module tick_timer (
    input  logic                    clk,
    input  logic                    global_resetn,
    input  soc_mmio_pkg::mmio_req_t req,
    output soc_mmio_pkg::mmio_rsp_t rsp,
    output logic                    timer_irq   // Sticky until cleared
);

    localparam int dw = soc_mmio_pkg::data_w;
    localparam int tw = soc_mmio_pkg::timer_w;

    logic [tw-1:0] period;                  // Ticks per interrupt
    logic [tw-1:0] count;
    logic          enable;                  // ctrl bit 0
    logic          pending;                 // status bit 0
    logic          accept;
    logic          wrap;
    logic [3:0]    off;

    assign accept    = req.valid && !rsp.ready;
    assign off       = req.addr[3:0];
    assign wrap      = enable && (count >= period - 1'b1);  // Last tick of period
    assign timer_irq = pending;

    // ========================================================================
    // Counter and registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!global_resetn) begin
            rsp.ready <= 1'b0;
            period    <= '0;
            count     <= '0;
            enable    <= 1'b0;
            pending   <= 1'b0;
        end else begin
            rsp.ready <= accept;

            if (!enable || wrap) count <= '0;   // Idle at zero
            else count <= count + 1'b1;

            if (accept && req.write) begin
                case (off)
                    soc_mmio_pkg::timer_off_period: period <= req.wdata[tw-1:0];
                    soc_mmio_pkg::timer_off_ctrl:   enable <= req.wdata[0];
                    soc_mmio_pkg::timer_off_status: if (req.wdata[0]) pending <= 1'b0;
                    default: ;                      // Count is read-only
                endcase
            end

            if (wrap) pending <= 1'b1;      // Wrap beats a same-cycle clear
        end
    end

    // Read data
    always_ff @(posedge clk) begin
        if (accept && !req.write) begin
            case (off)
                soc_mmio_pkg::timer_off_period: rsp.rdata <= dw'(period);
                soc_mmio_pkg::timer_off_ctrl:   rsp.rdata <= {{(dw-1){1'b0}}, enable};
                soc_mmio_pkg::timer_off_status: rsp.rdata <= {{(dw-1){1'b0}}, pending};
                default:                        rsp.rdata <= dw'(count);
            endcase
        end
    end

    // Firmware must load a period before enabling
    a_period_set : assert property (@(posedge clk) disable iff (!global_resetn)
        enable |-> period != '0)
        else $error("tick_timer: enabled with zero period");

endmodule

//--- mmio_periph_top.sv
`timescale 1ns/1ps

module mmio_periph_top #(
    parameter int rx_addr_bits = 4,         // 16-byte receive buffer
    parameter int sync_stages  = 2          // Two-flop button sync
) (
    input  logic                     clk,
    input  logic                     global_resetn,
    input  soc_mmio_pkg::mmio_req_t  req,   // CPU data port
    output soc_mmio_pkg::mmio_rsp_t  rsp,
    input  logic [1:0]               buttons_n,
    output logic [1:0]               leds,
    input  soc_mmio_pkg::byte_t      rx_byte,
    input  logic                     rx_valid,
    output soc_mmio_pkg::byte_t      tx_byte,
    output logic                     tx_valid,
    input  logic                     tx_busy,
    output soc_mmio_pkg::irq_lines_t irq
);

    soc_mmio_pkg::mmio_req_t io_req, uart_req, timer_req;
    soc_mmio_pkg::mmio_rsp_t io_rsp, uart_rsp, timer_rsp;

    // ========================================================================
    // Decode and response mux
    // ========================================================================
    mmio_bus_ctrl bus_ctrl_inst (
        .clk (clk), .global_resetn (global_resetn),
        .req (req), .rsp (rsp),
        .io_req (io_req), .uart_req (uart_req), .timer_req (timer_req),
        .io_rsp (io_rsp), .uart_rsp (uart_rsp), .timer_rsp (timer_rsp)
    );

    // ========================================================================
    // Peripherals
    // ========================================================================
    board_io #(
        .sync_stages (sync_stages)
    ) board_io_inst (
        .clk (clk), .global_resetn (global_resetn),
        .req (io_req), .rsp (io_rsp),
        .buttons_n (buttons_n), .leds (leds),
        .soft_irq (irq.soft_irq)
    );

    uart_regs #(
        .rx_addr_bits (rx_addr_bits)
    ) uart_regs_inst (
        .clk (clk), .global_resetn (global_resetn),
        .req (uart_req), .rsp (uart_rsp),
        .rx_byte (rx_byte), .rx_valid (rx_valid),
        .tx_byte (tx_byte), .tx_valid (tx_valid), .tx_busy (tx_busy)
    );

    tick_timer tick_timer_inst (
        .clk (clk), .global_resetn (global_resetn),
        .req (timer_req), .rsp (timer_rsp),
        .timer_irq (irq.timer_irq)
    );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter realtime half_period = 2.0    // 4 ns period
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(half_period) clk = ~clk;       // Free running

endmodule

//--- tb_mmio_periph.sv
`timescale 1ns/1ps

module tb_mmio_periph;

    localparam int rx_addr_bits = 4;
    localparam int sync_stages  = 2;
    localparam int rx_depth     = 1 << rx_addr_bits;
    localparam int bus_timeout  = 16;       // Cycles before a missing ready is fatal

    localparam logic [31:0] uart_tx_addr  = {soc_mmio_pkg::uart_base, soc_mmio_pkg::uart_off_tx};
    localparam logic [31:0] uart_rx_addr  = {soc_mmio_pkg::uart_base, soc_mmio_pkg::uart_off_rx};
    localparam logic [31:0] uart_st_addr  = {soc_mmio_pkg::uart_base,
                                             soc_mmio_pkg::uart_off_status};
    localparam logic [31:0] tmr_per_addr  = {soc_mmio_pkg::timer_base,
                                             soc_mmio_pkg::timer_off_period};
    localparam logic [31:0] tmr_ctrl_addr = {soc_mmio_pkg::timer_base,
                                             soc_mmio_pkg::timer_off_ctrl};
    localparam logic [31:0] tmr_st_addr   = {soc_mmio_pkg::timer_base,
                                             soc_mmio_pkg::timer_off_status};

    logic                     clk;
    logic                     global_resetn;
    soc_mmio_pkg::mmio_req_t  req;
    soc_mmio_pkg::mmio_rsp_t  rsp;
    logic [1:0]               buttons_n;
    logic [1:0]               leds;
    soc_mmio_pkg::byte_t      rx_byte;
    logic                     rx_valid;
    soc_mmio_pkg::byte_t      tx_byte;
    logic                     tx_valid;
    logic                     tx_busy;
    soc_mmio_pkg::irq_lines_t irq;

    // Reference model state
    soc_mmio_pkg::byte_t rx_model[$];       // Receive buffer, drop when full
    logic [1:0]          m_leds;
    logic [1:0]          m_btn;             // Pressed = 1
    logic [31:0]         m_period;
    logic                m_enable;
    logic                m_pending;
    logic [31:0]         rng_state = 32'd30943;

    // Read results waiting for the comparing process
    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] got_q[$];

    // Outputs captured at the ready sample point
    soc_mmio_pkg::irq_lines_t snap_irq;
    logic                     snap_tx_valid;
    soc_mmio_pkg::byte_t      snap_tx_byte;

    tb_clkgen clkgen_inst (.clk (clk));

    mmio_periph_top #(
        .rx_addr_bits (rx_addr_bits),
        .sync_stages  (sync_stages)
    ) mmio_periph_top_inst (
        .clk (clk), .global_resetn (global_resetn),
        .req (req), .rsp (rsp),
        .buttons_n (buttons_n), .leds (leds),
        .rx_byte (rx_byte), .rx_valid (rx_valid),
        .tx_byte (tx_byte), .tx_valid (tx_valid), .tx_busy (tx_busy),
        .irq (irq)
    );

    // ========================================================================
    // Reporting and compare tasks
    // ========================================================================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [soc_mmio_pkg::data_w-1:0] got,
                              input logic [soc_mmio_pkg::data_w-1:0] exp);
        if (got !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_byte(input string name, input soc_mmio_pkg::byte_t got,
                              input soc_mmio_pkg::byte_t exp);
        if (got !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_irq(input string name, input soc_mmio_pkg::irq_lines_t got,
                             input soc_mmio_pkg::irq_lines_t exp);
        if (got !== exp) stop_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    // ========================================================================
    // Stimulus helpers and reference functions
    // ========================================================================
    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Expected read data from the model, before any pop
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] val;
        val = '0;                                   // Unmapped and write-only words
        if (addr == soc_mmio_pkg::addr_led) val = {30'b0, m_leds};
        else if (addr == soc_mmio_pkg::addr_button) val = {30'b0, m_btn};
        else if (addr == uart_rx_addr && rx_model.size() > 0) val = {24'b0, rx_model[0]};
        else if (addr == uart_st_addr)
            val = {29'b0, rx_model.size() == rx_depth, rx_model.size() == 0, tx_busy};
        else if (addr == tmr_per_addr) val = m_period;
        else if (addr == tmr_ctrl_addr) val = {31'b0, m_enable};
        else if (addr == tmr_st_addr) val = {31'b0, m_pending};
        return val;
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;                                     // Drive and sample off the edge
        end
    endtask

    // One bus access, entered and left 1 ns after a rising edge
    task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
        int cycles;
        req.valid = 1'b1;
        req.write = wr;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = wstrb;
        cycles    = 0;
        do begin
            step(1);
            cycles++;
            if (cycles > bus_timeout)
                stop_run($sformatf("Bus timeout, no ready for address %h", addr));
        end while (!rsp.ready);
        rdata         = rsp.rdata;
        snap_irq      = irq;
        snap_tx_valid = tx_valid;
        snap_tx_byte  = tx_byte;
        if (cycles != 1)
            stop_run($sformatf("Ready for address %h came after %0d cycles, not 1",
                               addr, cycles));
        step(1);                                    // Valid still high on the ready edge
        if (rsp.ready)
            stop_run($sformatf("Ready for address %h lasted more than one cycle", addr));
        req           = '0;                         // Drop valid after ready
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
        logic [31:0] unused_rdata;
        bus_xfer(1'b1, addr, wdata, wstrb, unused_rdata);
    endtask

    // Read and queue the result for the comparing process
    task automatic read_check(input logic [31:0] addr);
        logic [31:0] exp_val;
        logic [31:0] got;
        exp_val = expected_read(addr);
        bus_xfer(1'b0, addr, '0, '0, got);
        name_q.push_back($sformatf("rdata[%h]", addr));
        exp_q.push_back(exp_val);
        got_q.push_back(got);
        if (addr == uart_rx_addr && rx_model.size() > 0) rx_model.delete(0);
    endtask

    task automatic rx_push(input soc_mmio_pkg::byte_t b);
        rx_byte  = b;
        rx_valid = 1'b1;
        if (rx_model.size() < rx_depth) rx_model.push_back(b);   // Overrun drops it
        step(1);
        rx_valid = 1'b0;
    endtask

    // Comparing process, drains between edges
    always @(negedge clk) begin
        while (got_q.size() > 0) begin
            check_word(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        logic [31:0]              r;
        logic [3:0]               strb;
        soc_mmio_pkg::irq_lines_t irq_exp;
        int                       per;
        int                       cycles;
        req = '0;
        buttons_n = 2'b11;                          // Released
        rx_byte = '0;
        rx_valid = 1'b0;
        tx_busy = 1'b0;
        global_resetn = 1'b0;
        m_leds = 2'b00;
        m_btn = 2'b00;
        m_period = '0;
        m_enable = 1'b0;
        m_pending = 1'b0;
        repeat (4) @(posedge clk);
        #1 global_resetn = 1'b1;

        check_irq("irq", irq, 2'b00);
        check_word("leds", {30'b0, leds}, 32'd0);
        check_bit("tx_valid", tx_valid, 1'b0);

        // Every region and two stray addresses
        read_check(soc_mmio_pkg::addr_led);
        read_check(soc_mmio_pkg::addr_button);
        read_check(uart_st_addr);
        read_check(tmr_ctrl_addr);
        read_check(32'h9000_0000);
        read_check(32'h8000_0030);

        // LEDs with random strobes
        for (int i = 0; i < 10; i++) begin
            r = xorshift32();
            strb = r[7:4];
            bus_write(soc_mmio_pkg::addr_led, r, strb);
            if (strb[0]) m_leds = r[1:0];
            check_word("leds", {30'b0, leds}, {30'b0, m_leds});
            read_check(soc_mmio_pkg::addr_led);
        end

        // Buttons through the synchroniser
        for (int i = 0; i < 8; i++) begin
            r = xorshift32();
            buttons_n = r[9:8];
            m_btn = ~r[9:8];
            step(sync_stages);
            read_check(soc_mmio_pkg::addr_button);
        end

        // Soft interrupt, one pulse with ready
        irq_exp = '0;
        irq_exp.soft_irq = 1'b1;
        bus_write(soc_mmio_pkg::addr_soft_irq, 32'd1, 4'hF);
        check_irq("irq", snap_irq, irq_exp);
        step(1);
        check_irq("irq", irq, 2'b00);
        read_check(soc_mmio_pkg::addr_soft_irq);

        // Receive buffer past its depth
        for (int i = 0; i < rx_depth + 3; i++) begin
            r = xorshift32();
            rx_push(r[7:0]);
        end
        read_check(uart_st_addr);
        for (int i = 0; i < rx_depth + 1; i++) read_check(uart_rx_addr);   // Last one empty
        read_check(uart_st_addr);

        // Transmit, free then busy
        for (int busy = 0; busy < 2; busy++) begin
            tx_busy = busy[0];
            r = xorshift32();
            bus_write(uart_tx_addr, {24'b0, r[7:0]}, 4'hF);
            check_bit("tx_valid", snap_tx_valid, !busy[0]);
            if (!busy[0]) check_byte("tx_byte", snap_tx_byte, r[7:0]);
            step(1);
            check_bit("tx_valid", tx_valid, 1'b0);
            read_check(uart_st_addr);
        end
        tx_busy = 1'b0;

        // Timer with a small random period
        r = xorshift32();
        per = 3 + int'(r[2:0]);
        bus_write(tmr_per_addr, per, 4'hF);
        m_period = per;
        bus_write(tmr_ctrl_addr, 32'd1, 4'hF);
        m_enable = 1'b1;
        read_check(tmr_per_addr);
        read_check(tmr_ctrl_addr);
        cycles = 0;
        while (!irq.timer_irq) begin
            step(1);
            cycles++;
            if (cycles > 4 * per + 20) stop_run("Timeout, timer_irq never rose");
        end
        m_pending = 1'b1;
        read_check(tmr_st_addr);
        bus_write(tmr_ctrl_addr, 32'd0, 4'hF);      // Stop before the clear
        m_enable = 1'b0;
        bus_write(tmr_st_addr, 32'd1, 4'hF);
        m_pending = 1'b0;
        check_irq("irq", irq, 2'b00);
        read_check(tmr_st_addr);
        for (int i = 0; i < 4 * per + 20; i++) begin
            step(1);
            check_irq("irq", irq, 2'b00);           // Disabled, stays quiet
        end

        step(2);                                    // Let the comparing process drain
        $display("** PASS **");
        $finish;
    end

endmodule

//--- flist.f
// Package first, the blocks next, the top level after them
soc_mmio_pkg.sv
mmio_bus_ctrl.sv
board_io.sv
uart_rx_fifo.sv
uart_regs.sv
tick_timer.sv
mmio_periph_top.sv
// Testbench
tb_clkgen.sv
tb_mmio_periph.sv

//--- Makefile
# Verilator build and run of the MMIO peripheral block

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search sim.log for the pass message"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_mmio_periph -f flist.f -o Vtb_mmio_periph
	./obj_dir/Vtb_mmio_periph > sim.log 2>&1; cat sim.log
	@grep -q '\*\* PASS \*\*' sim.log || (echo "Simulation failed, see sim.log"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
